// File: verification/uart_phy_cases.txt
# data ptype nstop corrupt exp_data exp_perr exp_ferr clear, all hex
# corrupt is the inverted frame bit: 0 start, 1-8 data LSB first, then parity, stop; ff none
a5 0 0 ff a5 0 0 0
3c 1 1 ff 3c 0 0 0
5a 2 0 ff 5a 0 0 0
c3 3 1 ff c3 0 0 0
00 2 1 ff 00 0 0 0
ff 3 0 ff ff 0 0 1
81 0 0 03 85 0 0 0
12 2 0 05 02 1 0 0
7e 0 1 ff 7e 1 0 1
4b 3 0 09 4b 1 0 0
e7 3 1 01 e6 1 0 1
99 0 0 09 99 0 1 0
24 2 1 0a 24 0 1 1
6d 1 0 08 ed 0 0 0
f0 2 0 ff f0 0 0 0
0f 3 0 0a 0f 0 1 0
55 0 1 ff 55 0 1 1
aa 3 1 ff aa 0 0 0
01 2 1 02 03 1 0 0
80 0 0 ff 80 1 0 1

// File: compile.f
src/uart_phy_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_status.sv
src/uart_phy.sv
verification/uart_clock_gen.sv
verification/uart_phy_checker.sv
verification/uart_phy_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UART PHY testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module uart_phy_tb -f compile.f -o uart_phy_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/uart_phy_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Simulation did not report a clean run"
exit 1

// File: verification/uart_phy_tb.sv
`default_nettype none

module uart_phy_tb;

  logic                                 clock;
  logic                                 reset;
  logic                                 tx_en;
  logic [1:0]                           parity_type;
  logic                                 nstop;
  logic [uart_phy_pkg::DATA_WIDTH-1:0]  data_in;
  logic                                 data_valid;
  logic                                 rxd;
  logic                                 clear_status;
  logic                                 txd;
  logic                                 tx_rdy;
  logic [uart_phy_pkg::DATA_WIDTH-1:0]  rx_data;
  logic                                 rx_valid;
  logic                                 parity_error;
  logic                                 framing_error;
  logic [uart_phy_pkg::COUNT_WIDTH-1:0] frame_count;

  // One case table entry per frame
  logic [7:0] c_data[$];
  logic [1:0] c_ptype[$];
  logic       c_nstop[$];
  logic [7:0] c_corrupt[$];  // Frame bit to invert or ff
  logic [7:0] c_exp_data[$];
  logic       c_exp_perr[$];  // Sticky flag after the frame
  logic       c_exp_ferr[$];
  logic       c_clear[$];     // Pulse clear_status after the frame

  integer     seed = 32'h4223d0a7;
  int         cycles = 0;
  int         cycle_limit = 50;
  logic [7:0] frames = '0;  // Completed since last clear

  uart_clock_gen clk_gen0 (
    .clock (clock)
  );

  uart_phy dut0 (
    .clock         (clock),
    .reset         (reset),
    .tx_en         (tx_en),
    .parity_type   (parity_type),
    .nstop         (nstop),
    .data_in       (data_in),
    .data_valid    (data_valid),
    .txd           (txd),
    .tx_rdy        (tx_rdy),
    .rxd           (rxd),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .clear_status  (clear_status),
    .parity_error  (parity_error),
    .framing_error (framing_error),
    .frame_count   (frame_count)
  );

  bind uart_phy uart_phy_checker checker0 (
    .clock    (clock),
    .reset    (reset),
    .txd      (txd),
    .rx_valid (rx_valid),
    .tx_state (u_tx.state)
  );

  // Run length guard
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout, the frames did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %02h got %02h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_state(input string name, input uart_phy_pkg::uart_phy_fsm_t exp,
                             input uart_phy_pkg::uart_phy_fsm_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %s got %s", $time, name, exp.name(),
               act.name());
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // One bit period of loopback with optional inversion
  task automatic step(input logic flip);
    @(posedge clock);
    #2;
    rxd = txd ^ flip;
  endtask

  // Line value for frame bit k where k = 0 is the start bit
  function automatic logic frame_bit(input logic [7:0] data, input logic [1:0] ptype,
                                     input int k);
    logic [7:0] shifted;
    logic       bit_val;
    shifted = data >> (k - 1);
    bit_val = 1'b1;  // Stop bits
    if (k == 0) begin
      bit_val = 1'b0;
    end else if (k <= 8) begin
      bit_val = shifted[0];  // LSB first
    end else if (k == 9 && ptype[1]) begin
      bit_val = (^data) ^ ptype[0];
    end
    return bit_val;
  endfunction

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    int    f_data;
    int    f_ptype;
    int    f_nstop;
    int    f_corrupt;
    int    f_exp;
    int    f_perr;
    int    f_ferr;
    int    f_clear;
    fd = $fopen("verification/uart_phy_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/uart_phy_cases.txt");
      $display("ERRORS FOUND");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != 8'h23) begin  // Skip # lines
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_data, f_ptype, f_nstop, f_corrupt,
                    f_exp, f_perr, f_ferr, f_clear);
        if (n == 8) begin
          c_data.push_back(8'(f_data));
          c_ptype.push_back(2'(f_ptype));
          c_nstop.push_back(1'(f_nstop));
          c_corrupt.push_back(8'(f_corrupt));
          c_exp_data.push_back(8'(f_exp));
          c_exp_perr.push_back(1'(f_perr));
          c_exp_ferr.push_back(1'(f_ferr));
          c_clear.push_back(1'(f_clear));
        end
      end
    end
    $fclose(fd);
    if (c_data.size() == 0) begin
      $display("The case file holds no frames");
      $display("ERRORS FOUND");
      $fatal(1, "no stimulus");
    end
  endtask

  task automatic run_frame(input int i);
    int         gap;
    int         flen;
    int         vk;
    int         k;
    logic [7:0] corrupt;
    gap     = $unsigned($random(seed)) % 3;
    corrupt = c_corrupt[i];
    flen    = 10 + int'(c_ptype[i][1]) + int'(c_nstop[i]);
    vk      = 10 + int'(c_ptype[i][1]);  // rx_valid cycle after the start bit
    repeat (gap) step(1'b0);
    parity_type = c_ptype[i];
    nstop       = c_nstop[i];
    data_in     = c_data[i];
    data_valid  = 1'b1;
    check_bit("tx_rdy", 1'b1, tx_rdy);
    step(corrupt == 8'd0);  // Acceptance edge
    data_valid = 1'b0;
    for (k = 0; k <= vk + 1; k++) begin
      if (k < flen) begin
        check_bit("txd", frame_bit(c_data[i], c_ptype[i], k), txd);
      end
      check_bit("tx_rdy", k >= flen, tx_rdy);  // Low for the whole frame
      check_bit("rx_valid", k == vk, rx_valid);
      if (k == vk) begin
        check_byte("rx_data", c_exp_data[i], rx_data);
        frames = frames + 8'd1;
      end
      if (k == vk + 1) begin
        // Status settles one cycle after rx_valid
        check_bit("parity_error", c_exp_perr[i], parity_error);
        check_bit("framing_error", c_exp_ferr[i], framing_error);
        check_byte("frame_count", frames, frame_count);
        check_state("u_tx.state", uart_phy_pkg::Idle, dut0.u_tx.state);
        check_state("u_rx.state", uart_phy_pkg::Idle, dut0.u_rx.state);
      end else begin
        step(corrupt == 8'(k + 1));
      end
    end
    if (c_clear[i]) begin
      clear_status = 1'b1;
      step(1'b0);
      clear_status = 1'b0;
      check_bit("parity_error", 1'b0, parity_error);
      check_bit("framing_error", 1'b0, framing_error);
      check_byte("frame_count", 8'd0, frame_count);
      frames = '0;
    end
  endtask

  initial begin
    reset        = 1'b1;
    tx_en        = 1'b1;
    parity_type  = uart_phy_pkg::PARITY_NONE0;
    nstop        = 1'b0;
    data_in      = '0;
    data_valid   = 1'b0;
    rxd          = 1'b1;  // Idle line
    clear_status = 1'b0;
    load_cases();
    cycle_limit = 20 * c_data.size() + 50;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    // Values straight out of reset
    check_bit("txd", 1'b1, txd);
    check_bit("tx_rdy", 1'b1, tx_rdy);
    check_bit("rx_valid", 1'b0, rx_valid);
    check_byte("rx_data", 8'd0, rx_data);
    check_bit("parity_error", 1'b0, parity_error);
    check_bit("framing_error", 1'b0, framing_error);
    check_byte("frame_count", 8'd0, frame_count);
    for (int i = 0; i < c_data.size(); i++) begin
      run_frame(i);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/uart_phy_checker.sv
`default_nettype none

module uart_phy_checker (
  input logic                        clock,
  input logic                        reset,
  input logic                        txd,
  input logic                        rx_valid,
  input uart_phy_pkg::uart_phy_fsm_t tx_state  // Transmitter sequencer
);

  // Line rests high between frames
  idle_line_high: assert property (
    @(posedge clock) disable iff (reset)
    (tx_state == uart_phy_pkg::Idle) |-> txd
  ) else $error("txd low while the transmitter is idle");

  // One cycle pulse per frame
  valid_single_pulse: assert property (
    @(posedge clock) disable iff (reset)
    rx_valid |=> !rx_valid
  ) else $error("rx_valid high for two cycles");

endmodule

`default_nettype wire

// File: verification/uart_clock_gen.sv
`default_nettype none

module uart_clock_gen (
  output logic clock
);

  // Free running, period 20
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // Half period
  end

endmodule

`default_nettype wire

// File: src/uart_phy.sv
`default_nettype none

module uart_phy (
  input  logic                                  clock,
  input  logic                                  reset,
  // Shared configuration
  input  logic                                  tx_en,
  input  logic [1:0]                            parity_type,
  input  logic                                  nstop,
  // Transmit side
  input  logic [uart_phy_pkg::DATA_WIDTH-1:0]   data_in,
  input  logic                                  data_valid,
  output logic                                  txd,
  output logic                                  tx_rdy,
  // Receive side
  input  logic                                  rxd,
  output logic [uart_phy_pkg::DATA_WIDTH-1:0]   rx_data,
  output logic                                  rx_valid,
  // Status
  input  logic                                  clear_status,
  output logic                                  parity_error,
  output logic                                  framing_error,
  output logic [uart_phy_pkg::COUNT_WIDTH-1:0]  frame_count
);

  logic rx_parity_err;  // Per frame, with rx_valid
  logic rx_frame_err;

  uart_tx u_tx (
    .clock       (clock),
    .reset       (reset),
    .tx_en       (tx_en),
    .parity_type (parity_type),
    .nstop       (nstop),
    .data_in     (data_in),
    .data_valid  (data_valid),
    .txd         (txd),
    .tx_rdy      (tx_rdy)
  );

  uart_rx u_rx (
    .clock         (clock),
    .reset         (reset),
    .tx_en         (tx_en),
    .parity_type   (parity_type),
    .nstop         (nstop),
    .rxd           (rxd),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  // Folds per frame results into sticky status
  uart_status u_status (
    .clock         (clock),
    .reset         (reset),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err),
    .clear_status  (clear_status),
    .parity_error  (parity_error),
    .framing_error (framing_error),
    .frame_count   (frame_count)
  );

endmodule

`default_nettype wire

// File: src/uart_status.sv
`default_nettype none

module uart_status (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  rx_valid,       // Frame done
  input  logic                                  rx_parity_err,
  input  logic                                  rx_frame_err,
  input  logic                                  clear_status,   // Beats rx_valid
  output logic                                  parity_error,   // Sticky
  output logic                                  framing_error,  // Sticky
  output logic [uart_phy_pkg::COUNT_WIDTH-1:0]  frame_count     // Wraps at 256
);

  // Sticky flags
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      parity_error  <= 1'b0;
      framing_error <= 1'b0;
    end else if (clear_status) begin
      parity_error  <= 1'b0;
      framing_error <= 1'b0;
    end else if (rx_valid) begin
      parity_error  <= parity_error | rx_parity_err;
      framing_error <= framing_error | rx_frame_err;
    end
  end

  // Completed frames since last clear
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      frame_count <= '0;
    end else if (clear_status) begin
      frame_count <= '0;
    end else if (rx_valid) begin
      frame_count <= frame_count + 1'b1;  // Natural wrap
    end
  end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`default_nettype none

module uart_rx (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 tx_en,          // Shared enable, holds rx in Idle
  input  logic [1:0]                           parity_type,
  input  logic                                 nstop,          // Not checked, see below
  input  logic                                 rxd,            // Serial line in
  output logic [uart_phy_pkg::DATA_WIDTH-1:0]  rx_data,        // Held until next frame
  output logic                                 rx_valid,       // One cycle per frame
  output logic                                 rx_parity_err,  // Valid with rx_valid
  output logic                                 rx_frame_err    // Valid with rx_valid
);

  uart_phy_pkg::uart_phy_fsm_t state, next_state;

  logic [uart_phy_pkg::DATA_WIDTH-1:0] shift_reg;  // Incoming byte
  logic [uart_phy_pkg::CNT_WIDTH-1:0]  bit_cnt;
  logic                                par_acc;     // Running XOR, seeded with odd bit
  logic                                par_bad;     // Parity bit disagreed
  logic                                has_parity;
  logic                                odd_parity;

  // Second stop bit is left to the Idle rule
  // rxd must be high before a new start is taken
  // so nstop needs no state of its own here

  // Decode of the parity setting
  always_comb begin
    has_parity = 1'b0;
    odd_parity = 1'b0;
    case (parity_type)
      uart_phy_pkg::PARITY_NONE0, uart_phy_pkg::PARITY_NONE1: begin
        has_parity = 1'b0;
      end
      uart_phy_pkg::PARITY_EVEN: begin
        has_parity = 1'b1;
      end
      uart_phy_pkg::PARITY_ODD: begin
        has_parity = 1'b1;
        odd_parity = 1'b1;
      end
    endcase
  end

  // LSB arrives first, enters at the top
  always_ff @(posedge clock) begin
    if (state == uart_phy_pkg::Data) begin
      shift_reg <= {rxd, shift_reg[uart_phy_pkg::DATA_WIDTH-1:1]};
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      bit_cnt <= '0;
      par_acc <= 1'b0;
      par_bad <= 1'b0;
    end else begin
      case (state)
        uart_phy_pkg::Idle: begin
          bit_cnt <= '0;
          par_acc <= odd_parity;
          par_bad <= 1'b0;
        end
        uart_phy_pkg::Data: begin
          bit_cnt <= bit_cnt + 1'b1;
          par_acc <= par_acc ^ rxd;
        end
        uart_phy_pkg::Parity: begin
          par_bad <= rxd ^ par_acc;  // Received vs computed
        end
        default: begin
        end
      endcase
    end
  end

  // Results land on the stop sample
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      rx_data       <= '0;
      rx_valid      <= 1'b0;
      rx_parity_err <= 1'b0;
      rx_frame_err  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (state == uart_phy_pkg::Stop1) begin
        rx_data       <= shift_reg;
        rx_valid      <= 1'b1;
        rx_parity_err <= par_bad;
        rx_frame_err  <= ~rxd;  // Stop bit must be 1
      end
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= uart_phy_pkg::Idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      uart_phy_pkg::Idle: begin
        if (tx_en && !rxd) begin
          next_state = uart_phy_pkg::Data;  // Start bit sampled here
        end
      end
      uart_phy_pkg::Data: begin
        if (&bit_cnt) begin
          next_state = has_parity ? uart_phy_pkg::Parity : uart_phy_pkg::Stop1;
        end
      end
      uart_phy_pkg::Parity: begin
        next_state = uart_phy_pkg::Stop1;
      end
      uart_phy_pkg::Stop1: begin
        // Low stop bit, wait for the line to recover
        next_state = rxd ? uart_phy_pkg::Idle : uart_phy_pkg::Stop2;
      end
      uart_phy_pkg::Stop2: begin
        if (rxd) begin
          next_state = uart_phy_pkg::Idle;
        end
      end
      default: begin
        next_state = uart_phy_pkg::Idle;  // Start and unused codes
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`default_nettype none

module uart_tx (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 tx_en,        // Transmitter enable
  input  logic [1:0]                           parity_type,  // Bit 1 on, bit 0 odd
  input  logic                                 nstop,        // Two stop bits when set
  input  logic [uart_phy_pkg::DATA_WIDTH-1:0]  data_in,
  input  logic                                 data_valid,   // Level, data_in holds a byte
  output logic                                 txd,          // Serial line
  output logic                                 tx_rdy        // High only in Idle
);

  uart_phy_pkg::uart_phy_fsm_t state, next_state;

  logic [uart_phy_pkg::DATA_WIDTH-1:0] data_reg;  // Outgoing byte, shifts right
  logic                                tx_parity;  // Parity bit for this frame
  logic [uart_phy_pkg::CNT_WIDTH-1:0]  data_cnt;   // Position inside Data
  logic                                accept;

  // Byte taken only from Idle
  assign accept = (state == uart_phy_pkg::Idle) && tx_en && data_valid;

  // Parallel to serial
  always_ff @(posedge clock) begin
    if (accept) begin
      data_reg <= data_in;
    end else if (state == uart_phy_pkg::Data) begin
      data_reg <= {1'b0, data_reg[uart_phy_pkg::DATA_WIDTH-1:1]};  // Next bit into [0]
    end
  end

  // Whole byte still in place during Start
  always_ff @(posedge clock) begin
    if (state == uart_phy_pkg::Start) begin
      tx_parity <= (^data_reg) ^ parity_type[0];
    end
  end

  // Counts the eight data bits
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      data_cnt <= '0;
    end else if (state == uart_phy_pkg::Start) begin
      data_cnt <= '0;
    end else if (state == uart_phy_pkg::Data) begin
      data_cnt <= data_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= uart_phy_pkg::Idle;
    end else begin
      state <= next_state;
    end
  end

  // Line value and sequencing per state
  always_comb begin
    txd        = 1'b1;  // Line idles high
    tx_rdy     = 1'b0;
    next_state = state;
    case (state)
      uart_phy_pkg::Idle: begin
        tx_rdy = 1'b1;
        if (accept) begin
          next_state = uart_phy_pkg::Start;
        end
      end
      uart_phy_pkg::Start: begin
        txd        = 1'b0;
        next_state = uart_phy_pkg::Data;
      end
      uart_phy_pkg::Data: begin
        txd = data_reg[0];  // LSB first
        if (&data_cnt) begin
          // Eighth bit out
          next_state = parity_type[1] ? uart_phy_pkg::Parity : uart_phy_pkg::Stop1;
        end
      end
      uart_phy_pkg::Parity: begin
        txd        = tx_parity;
        next_state = uart_phy_pkg::Stop1;
      end
      uart_phy_pkg::Stop1: begin
        next_state = nstop ? uart_phy_pkg::Stop2 : uart_phy_pkg::Idle;
      end
      uart_phy_pkg::Stop2: begin
        next_state = uart_phy_pkg::Idle;
      end
      default: begin
        next_state = uart_phy_pkg::Idle;  // Unused encodings
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/uart_phy_pkg.sv
`default_nettype none

package uart_phy_pkg;

  // Frame sequencer states
  typedef enum logic [2:0] {
    Idle   = 3'd0,  // Line high, waiting
    Start  = 3'd1,  // Start bit on the line
    Data   = 3'd2,  // Data bits, LSB first
    Parity = 3'd3,  // Optional parity bit
    Stop1  = 3'd4,  // First stop bit
    Stop2  = 3'd5   // Second stop bit on tx, line recovery on rx
  } uart_phy_fsm_t;

  // Data word
  localparam int DATA_WIDTH = 8;

  // Bit counter inside Data, all ones on the last bit
  localparam int CNT_WIDTH = 3;

  // parity_type codes
  // Bit 1 turns the parity bit on
  // Bit 0 is folded into the data parity
  localparam logic [1:0] PARITY_NONE0 = 2'd0;
  localparam logic [1:0] PARITY_NONE1 = 2'd1;
  localparam logic [1:0] PARITY_EVEN  = 2'd2;
  localparam logic [1:0] PARITY_ODD   = 2'd3;

  // Received frame counter, wraps
  localparam int COUNT_WIDTH = 8;

endpackage

`default_nettype wire
